/* flist.f */
+incdir+common
common/cpu6_isa_pkg.sv
common/cpu6_ctrl_pkg.sv
datapath/cpu6_alu.sv
datapath/cpu6_regfile.sv
datapath/cpu6_datapath.sv
rtl/cpu6_controller.sv
rtl/cpu6_csr.sv
rtl/cpu6_core.sv
tests/tb_cpu6_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module tb_cpu6_core -o simv > build.log 2>&1 &&
   ./obj_dir/simv > sim.log 2>&1 ||
   { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
! grep -q "=== FAIL ===" sim.log && grep -q "=== PASS ===" sim.log

/* tests/tb_cpu6_core.sv */
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module tb_cpu6_core;

   localparam int STORE_TIMEOUT = 200;
   localparam int HANDLER_INDEX = 40;

   // RV32I opcodes and fixed words
   localparam logic [6:0]  OPC_REG    = 7'b0110011;
   localparam logic [6:0]  OPC_IMM    = 7'b0010011;
   localparam logic [6:0]  OPC_LUI    = 7'b0110111;
   localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
   localparam logic [6:0]  OPC_STORE  = 7'b0100011;
   localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
   localparam logic [6:0]  OPC_JAL    = 7'b1101111;
   localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
   localparam logic [11:0] ADDR_MTVEC = 12'h305;
   localparam logic [11:0] ADDR_MEPC  = 12'h341;
   localparam logic [31:0] MRET_WORD    = 32'h3020_0073;
   localparam logic [31:0] ILLEGAL_WORD = 32'hFFFF_FFFF;
   // jal x0, 0 spins in place
   localparam logic [31:0] SELF_LOOP    = 32'h0000_006F;

   logic                  clk;
   logic                  rstN;
   logic [`CPU6_XLEN-1:0] pcF;
   logic [`CPU6_XLEN-1:0] instr;
   logic                  memWrite;
   logic [`CPU6_XLEN-1:0] dataAddr;
   logic [`CPU6_XLEN-1:0] writeData;
   logic [`CPU6_XLEN-1:0] readData;

   logic [31:0]           rom [64];
   logic [31:0]           ram [64];
   int                    progLen;
   logic [31:0]           expAddrQ [$];
   logic [31:0]           expDataQ [$];
   string                 expNameQ [$];
   int                    passCount;
   int                    failCount;

   cpu6_core uut (
      .clk       (clk),
      .rstN      (rstN),
      .pcF       (pcF),
      .instr     (instr),
      .memWrite  (memWrite),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .readData  (readData)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // combinational word-addressed ROM and RAM reads
   assign instr    = rom[pcF[7:2]];
   assign readData = ram[dataAddr[7:2]];

   always @(posedge clk) begin
      if (memWrite) begin
         ram[dataAddr[7:2]] <= writeData;
      end
   end

   function automatic logic [31:0] rFormat(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OPC_REG};
   endfunction

   function automatic logic [31:0] iFormat(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   // always SW
   function automatic logic [31:0] sFormat(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
   endfunction

   function automatic logic [31:0] bFormat(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
   endfunction

   function automatic logic [31:0] uFormat(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, OPC_LUI};
   endfunction

   function automatic logic [31:0] jFormat(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
   endfunction

   function automatic logic [31:0] signExtend12(input logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   task automatic putInstr(input logic [31:0] word);
      rom[progLen] = word;
      progLen++;
   endtask

   task automatic expectStore(input string name, input logic [31:0] addr,
                              input logic [31:0] data);
      expNameQ.push_back(name);
      expAddrQ.push_back(addr);
      expDataQ.push_back(data);
   endtask

   task automatic buildProgram();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] base;
      logic [31:0] jalAddr;
      logic [31:0] trapAddr;
      logic [31:0] handlerAddr;
      a           = signExtend12(12'h5A3);
      b           = signExtend12(12'hC3E);
      base        = 32'h0000_0080;
      handlerAddr = HANDLER_INDEX * 4;
      for (int k = 0; k < 64; k++) begin
         rom[k] = SELF_LOOP;
         ram[k] = 32'hA5A5_0000 + k * 4;
      end
      progLen = 0;
      // a store at the reset PC reaches E at once if the reset bubble is missing
      putInstr(sFormat(12'h0B8, 5'd0, 5'd0));
      expectStore("x0 store", 32'h0000_00B8, 32'h0000_0000);
      putInstr(iFormat(12'h5A3, 5'd0, 3'b000, 5'd1, OPC_IMM));
      putInstr(iFormat(12'hC3E, 5'd0, 3'b000, 5'd2, OPC_IMM));
      putInstr(iFormat(base[11:0], 5'd0, 3'b000, 5'd10, OPC_IMM));
      putInstr(sFormat(12'd0, 5'd1, 5'd10));
      expectStore("addi", base, a);
      putInstr(rFormat(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
      putInstr(sFormat(12'd4, 5'd3, 5'd10));
      expectStore("add", base + 32'd4, a + b);
      putInstr(rFormat(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
      putInstr(sFormat(12'd8, 5'd4, 5'd10));
      expectStore("sub", base + 32'd8, a - b);
      putInstr(rFormat(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
      putInstr(sFormat(12'd12, 5'd5, 5'd10));
      expectStore("and", base + 32'd12, a & b);
      putInstr(rFormat(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
      putInstr(sFormat(12'd16, 5'd6, 5'd10));
      expectStore("or", base + 32'd16, a | b);
      putInstr(uFormat(20'hABCDE, 5'd7));
      putInstr(sFormat(12'd20, 5'd7, 5'd10));
      expectStore("lui", base + 32'd20, {20'hABCDE, 12'h000});
      // store, load back, store plus one
      putInstr(sFormat(12'd24, 5'd2, 5'd10));
      expectStore("sw", base + 32'd24, b);
      putInstr(iFormat(12'd24, 5'd10, 3'b010, 5'd8, OPC_LOAD));
      putInstr(iFormat(12'd1, 5'd8, 3'b000, 5'd8, OPC_IMM));
      putInstr(sFormat(12'd28, 5'd8, 5'd10));
      expectStore("lw plus one", base + 32'd28, b + 32'd1);
      // marker stores below must never happen
      putInstr(iFormat(12'h3EE, 5'd0, 3'b000, 5'd9, OPC_IMM));
      putInstr(bFormat(13'd8, 5'd1, 5'd1, 3'b000));
      putInstr(sFormat(12'd32, 5'd9, 5'd10));
      putInstr(bFormat(13'd8, 5'd1, 5'd1, 3'b001));
      putInstr(sFormat(12'd36, 5'd3, 5'd10));
      expectStore("bne fall through", base + 32'd36, a + b);
      jalAddr = progLen * 4;
      putInstr(jFormat(21'd8, 5'd11));
      putInstr(sFormat(12'd40, 5'd9, 5'd10));
      putInstr(sFormat(12'd44, 5'd11, 5'd10));
      expectStore("jal link", base + 32'd44, jalAddr + 32'd4);
      putInstr(iFormat(handlerAddr[11:0], 5'd0, 3'b000, 5'd12, OPC_IMM));
      putInstr(iFormat(ADDR_MTVEC, 5'd12, 3'b001, 5'd0, OPC_SYSTEM));
      trapAddr = progLen * 4;
      putInstr(ILLEGAL_WORD);
      // MRET lands here
      putInstr(iFormat(12'h4D2, 5'd0, 3'b000, 5'd13, OPC_IMM));
      putInstr(sFormat(12'd52, 5'd13, 5'd10));
      // trap handler reports mepc then skips the illegal word
      progLen = HANDLER_INDEX;
      putInstr(iFormat(ADDR_MEPC, 5'd0, 3'b010, 5'd14, OPC_SYSTEM));
      putInstr(sFormat(12'd48, 5'd14, 5'd10));
      putInstr(iFormat(12'd4, 5'd14, 3'b000, 5'd14, OPC_IMM));
      putInstr(iFormat(ADDR_MEPC, 5'd14, 3'b001, 5'd0, OPC_SYSTEM));
      putInstr(MRET_WORD);
      expectStore("mepc in handler", base + 32'd48, trapAddr);
      expectStore("after mret", base + 32'd52, signExtend12(12'h4D2));
   endtask

   task automatic checkPc(input logic [`CPU6_XLEN-1:0] expPc);
      if (pcF !== expPc) begin
         $display("[FAIL] t=%0t pcF got %h expected %h", $time, pcF, expPc);
         failCount++;
      end else begin
         $display("[PASS] reset pc %h", pcF);
         passCount++;
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic expVal);
      if (got !== expVal) begin
         $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, expVal);
         failCount++;
      end else begin
         $display("[PASS] %s is %b", name, got);
         passCount++;
      end
   endtask

   task automatic checkStore(input int idx, input string name,
                             input logic [`CPU6_XLEN-1:0] expAddr,
                             input logic [`CPU6_XLEN-1:0] expData);
      logic ok;
      ok = 1'b1;
      if (dataAddr !== expAddr) begin
         $display("[FAIL] t=%0t store %0d %s dataAddr got %h expected %h",
                  $time, idx, name, dataAddr, expAddr);
         ok = 1'b0;
      end
      if (writeData !== expData) begin
         $display("[FAIL] t=%0t store %0d %s writeData got %h expected %h",
                  $time, idx, name, writeData, expData);
         ok = 1'b0;
      end
      if (ok) begin
         $display("[PASS] store %0d %s addr %h data %h", idx, name, dataAddr, writeData);
         passCount++;
      end else begin
         failCount++;
      end
   endtask

   initial begin
      int   n;
      int   cycles;
      logic found;
      logic timedOut;
      rstN      = 1'b0;
      passCount = 0;
      failCount = 0;
      timedOut  = 1'b0;
      buildProgram();
      repeat (3) @(posedge clk);
      #1 rstN = 1'b1;

      // first cycle out of reset
      @(negedge clk);
      checkPc(`CPU6_RESET_PC);
      checkFlag("memWrite after reset", memWrite, 1'b0);

      n = 0;
      while (n < expAddrQ.size() && !timedOut) begin
         found  = 1'b0;
         cycles = 0;
         while (!found && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (memWrite === 1'b1) begin
               found = 1'b1;
            end
         end
         if (found) begin
            checkStore(n, expNameQ[n], expAddrQ[n], expDataQ[n]);
         end else begin
            $display("store %0d (%s) did not happen within %0d cycles",
                     n, expNameQ[n], STORE_TIMEOUT);
            failCount++;
            timedOut = 1'b1;
         end
         n++;
      end

      $display("tests %0d, passed %0d, failed %0d", passCount + failCount, passCount, failCount);
      if (failCount == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* rtl/cpu6_core.sv */
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module cpu6_core (
   input  logic                  clk,
   input  logic                  rstN,
   output logic [`CPU6_XLEN-1:0] pcF,
   input  logic [`CPU6_XLEN-1:0] instr,
   output logic                  memWrite,
   output logic [`CPU6_XLEN-1:0] dataAddr,
   output logic [`CPU6_XLEN-1:0] writeData,
   input  logic [`CPU6_XLEN-1:0] readData
);
   import cpu6_isa_pkg::*;
   import cpu6_ctrl_pkg::*;

   instrWord_u              instrF;
   logic                    memWriteF;
   logic                    memToRegF;
   logic                    aluSrcF;
   logic                    regWriteF;
   logic                    jumpF;
   logic                    mretDecF;
   logic                    illegalF;
   aluOp_e                  aluOpF;
   immType_e                immTypeF;
   branchType_e             branchTypeF;
   csrOp_e                  csrOpF;

   instrWord_u              instrE;
   logic [`CPU6_XLEN-1:0]   pcE;
   logic                    memWriteE;
   logic                    memToRegE;
   logic                    aluSrcE;
   logic                    regWriteE;
   logic                    jumpE;
   aluOp_e                  aluOpE;
   immType_e                immTypeE;
   branchType_e             branchTypeE;
   csrOp_e                  csrOpE;

   logic                    pcSrcE;
   logic [`CPU6_XLEN-1:0]   pcNextE;
   logic [`CPU6_XLEN-1:0]   pcNextF;
   logic                    trapF;
   logic                    mretF;
   logic                    flushE;
   logic [11:0]             csrAddrE;
   logic [`CPU6_XLEN-1:0]   csrWdataE;
   logic [`CPU6_XLEN-1:0]   csrRdata;
   logic [`CPU6_XLEN-1:0]   trapPc;

   assign instrF = instr;

   cpu6_controller controller (
      .instr      (instrF),
      .memWrite   (memWriteF),
      .memToReg   (memToRegF),
      .aluSrc     (aluSrcF),
      .regWrite   (regWriteF),
      .jump       (jumpF),
      .mret       (mretDecF),
      .illegal    (illegalF),
      .aluOp      (aluOpF),
      .immType    (immTypeF),
      .branchType (branchTypeF),
      .csrOp      (csrOpF)
   );

   // a taken branch in E squashes F, so its trap or return must not fire
   assign trapF  = illegalF & ~pcSrcE;
   assign mretF  = mretDecF & ~pcSrcE;
   assign flushE = pcSrcE | trapF | mretF;

   assign pcNextF = pcSrcE          ? pcNextE :
                    (trapF | mretF) ? trapPc  :
                    pcF + `CPU6_XLEN'd4;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pcF <= `CPU6_RESET_PC;
      end else begin
         pcF <= pcNextF;
      end
   end

   // ID/EX control fields that a flush clears to a bubble
   always_ff @(posedge clk) begin
      if (!rstN || flushE) begin
         memWriteE   <= 1'b0;
         memToRegE   <= 1'b0;
         aluSrcE     <= 1'b0;
         regWriteE   <= 1'b0;
         jumpE       <= 1'b0;
         aluOpE      <= ALU_ADD;
         immTypeE    <= IMM_I;
         branchTypeE <= BR_NONE;
         csrOpE      <= CSR_NONE;
      end else begin
         memWriteE   <= memWriteF;
         memToRegE   <= memToRegF;
         aluSrcE     <= aluSrcF;
         regWriteE   <= regWriteF;
         jumpE       <= jumpF;
         aluOpE      <= aluOpF;
         immTypeE    <= immTypeF;
         branchTypeE <= branchTypeF;
         csrOpE      <= csrOpF;
      end
   end

   // ID/EX payload
   always_ff @(posedge clk) begin
      instrE <= instrF;
      pcE    <= pcF;
   end

   cpu6_csr csr (
      .clk       (clk),
      .rstN      (rstN),
      .trapF     (trapF),
      .mretF     (mretF),
      .pcF       (pcF),
      .csrOpE    (csrOpE),
      .csrAddrE  (csrAddrE),
      .csrWdataE (csrWdataE),
      .csrRdata  (csrRdata),
      .trapPc    (trapPc)
   );

   cpu6_datapath datapath (
      .clk         (clk),
      .rstN        (rstN),
      .instrE      (instrE),
      .pcE         (pcE),
      .memWriteE   (memWriteE),
      .memToRegE   (memToRegE),
      .aluSrcE     (aluSrcE),
      .regWriteE   (regWriteE),
      .jumpE       (jumpE),
      .aluOpE      (aluOpE),
      .immTypeE    (immTypeE),
      .branchTypeE (branchTypeE),
      .csrOpE      (csrOpE),
      .csrRdata    (csrRdata),
      .csrAddrE    (csrAddrE),
      .csrWdataE   (csrWdataE),
      .pcSrcE      (pcSrcE),
      .pcNextE     (pcNextE),
      .memWrite    (memWrite),
      .dataAddr    (dataAddr),
      .writeData   (writeData),
      .readData    (readData)
   );

endmodule

/* rtl/cpu6_csr.sv */
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module cpu6_csr (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  trapF,
   input  logic                  mretF,
   input  logic [`CPU6_XLEN-1:0] pcF,
   input  cpu6_ctrl_pkg::csrOp_e csrOpE,
   input  logic [11:0]           csrAddrE,
   input  logic [`CPU6_XLEN-1:0] csrWdataE,
   output logic [`CPU6_XLEN-1:0] csrRdata,
   output logic [`CPU6_XLEN-1:0] trapPc
);
   import cpu6_isa_pkg::*;
   import cpu6_ctrl_pkg::*;

   logic [`CPU6_XLEN-1:0] mtvec;
   logic [`CPU6_XLEN-1:0] mepc;
   logic [`CPU6_XLEN-1:0] csrNew;
   logic                  wrMtvec;
   logic                  wrMepc;

   assign csrRdata = (csrAddrE == CSR_MTVEC) ? mtvec :
                     (csrAddrE == CSR_MEPC)  ? mepc  : '0;

   assign csrNew  = (csrOpE == CSR_SET) ? (csrRdata | csrWdataE) : csrWdataE;
   assign wrMtvec = (csrOpE != CSR_NONE) && (csrAddrE == CSR_MTVEC);
   assign wrMepc  = (csrOpE != CSR_NONE) && (csrAddrE == CSR_MEPC);

   // the redirect sees a CSR write that E does in the same cycle,
   // so an MRET right after setting mepc returns to the new address
   assign trapPc = mretF ? (wrMepc ? csrNew : mepc) :
                           (wrMtvec ? csrNew : mtvec);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         mtvec <= '0;
         mepc  <= '0;
      end else begin
         if (wrMtvec) begin
            mtvec <= csrNew;
         end
         // trap capture wins over a CSR write from E
         if (trapF) begin
            mepc <= pcF;
         end else if (wrMepc) begin
            mepc <= csrNew;
         end
      end
   end

endmodule

/* rtl/cpu6_controller.sv */
`timescale 1ns/1ps

module cpu6_controller (
   input  cpu6_isa_pkg::instrWord_u   instr,
   output logic                       memWrite,
   output logic                       memToReg,
   output logic                       aluSrc,
   output logic                       regWrite,
   output logic                       jump,
   output logic                       mret,
   output logic                       illegal,
   output cpu6_ctrl_pkg::aluOp_e      aluOp,
   output cpu6_ctrl_pkg::immType_e    immType,
   output cpu6_ctrl_pkg::branchType_e branchType,
   output cpu6_ctrl_pkg::csrOp_e      csrOp
);
   import cpu6_isa_pkg::*;
   import cpu6_ctrl_pkg::*;

   logic [6:0]  funct7;
   logic [2:0]  funct3;
   logic [11:0] csrAddr;
   logic        csrKnown;

   assign funct7   = instr.rType.funct7;
   assign funct3   = instr.rType.funct3;
   // the CSR address occupies funct7 and rs2
   assign csrAddr  = {instr.rType.funct7, instr.rType.rs2};
   assign csrKnown = (csrAddr == CSR_MTVEC) || (csrAddr == CSR_MEPC);

   always_comb begin
      memWrite   = 1'b0;
      memToReg   = 1'b0;
      aluSrc     = 1'b0;
      regWrite   = 1'b0;
      jump       = 1'b0;
      mret       = 1'b0;
      illegal    = 1'b0;
      aluOp      = ALU_ADD;
      immType    = IMM_I;
      branchType = BR_NONE;
      csrOp      = CSR_NONE;

      case (instr.rType.opcode)
         OPC_OP: begin
            regWrite = 1'b1;
            if (funct3 == 3'b000 && funct7 == 7'b0000000) aluOp = ALU_ADD;
            else if (funct3 == 3'b000 && funct7 == 7'b0100000) aluOp = ALU_SUB;
            else if (funct3 == 3'b111 && funct7 == 7'b0000000) aluOp = ALU_AND;
            else if (funct3 == 3'b110 && funct7 == 7'b0000000) aluOp = ALU_OR;
            else begin
               regWrite = 1'b0;
               illegal  = 1'b1;
            end
         end
         OPC_OP_IMM: begin
            // only ADDI
            aluSrc   = 1'b1;
            regWrite = (funct3 == 3'b000);
            illegal  = (funct3 != 3'b000);
         end
         OPC_LUI: begin
            aluSrc   = 1'b1;
            regWrite = 1'b1;
            immType  = IMM_U;
            aluOp    = ALU_PASSB;
         end
         OPC_LOAD: begin
            aluSrc   = 1'b1;
            memToReg = 1'b1;
            regWrite = (funct3 == 3'b010);
            illegal  = (funct3 != 3'b010);
         end
         OPC_STORE: begin
            aluSrc   = 1'b1;
            immType  = IMM_S;
            memWrite = (funct3 == 3'b010);
            illegal  = (funct3 != 3'b010);
         end
         OPC_BRANCH: begin
            immType = IMM_B;
            aluOp   = ALU_SUB;
            if (funct3 == 3'b000) branchType = BR_EQ;
            else if (funct3 == 3'b001) branchType = BR_NE;
            else illegal = 1'b1;
         end
         OPC_JAL: begin
            jump     = 1'b1;
            regWrite = 1'b1;
            immType  = IMM_J;
         end
         OPC_SYSTEM: begin
            if (funct3 == 3'b001 && csrKnown) begin
               csrOp    = CSR_WRITE;
               regWrite = 1'b1;
            end else if (funct3 == 3'b010 && csrKnown) begin
               csrOp    = CSR_SET;
               regWrite = 1'b1;
            end else if (instr == 32'h3020_0073) begin
               mret = 1'b1;
            end else begin
               illegal = 1'b1;
            end
         end
         default: illegal = 1'b1;
      endcase
   end

endmodule

/* datapath/cpu6_datapath.sv */
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module cpu6_datapath (
   input  logic                       clk,
   input  logic                       rstN,
   input  cpu6_isa_pkg::instrWord_u   instrE,
   input  logic [`CPU6_XLEN-1:0]      pcE,
   input  logic                       memWriteE,
   input  logic                       memToRegE,
   input  logic                       aluSrcE,
   input  logic                       regWriteE,
   input  logic                       jumpE,
   input  cpu6_ctrl_pkg::aluOp_e      aluOpE,
   input  cpu6_ctrl_pkg::immType_e    immTypeE,
   input  cpu6_ctrl_pkg::branchType_e branchTypeE,
   input  cpu6_ctrl_pkg::csrOp_e      csrOpE,
   input  logic [`CPU6_XLEN-1:0]      csrRdata,
   output logic [11:0]                csrAddrE,
   output logic [`CPU6_XLEN-1:0]      csrWdataE,
   output logic                       pcSrcE,
   output logic [`CPU6_XLEN-1:0]      pcNextE,
   output logic                       memWrite,
   output logic [`CPU6_XLEN-1:0]      dataAddr,
   output logic [`CPU6_XLEN-1:0]      writeData,
   input  logic [`CPU6_XLEN-1:0]      readData
);
   import cpu6_isa_pkg::*;
   import cpu6_ctrl_pkg::*;

   logic [`CPU6_XLEN-1:0] rd1;
   logic [`CPU6_XLEN-1:0] rd2;
   logic [`CPU6_XLEN-1:0] immE;
   logic [`CPU6_XLEN-1:0] srcB;
   logic [`CPU6_XLEN-1:0] aluY;
   logic                  aluZero;
   logic [`CPU6_XLEN-1:0] resultE;
   logic                  branchTaken;
   logic                  rfWe;
   rType_s                r;
   iType_s                i;

   assign r = instrE.rType;
   assign i = instrE.iType;

   // rebuild the immediate from its scattered fields
   always_comb begin
      case (immTypeE)
         IMM_S:   immE = {{20{r.funct7[6]}}, r.funct7, r.rd};
         IMM_B:   immE = {{20{r.funct7[6]}}, r.rd[0], r.funct7[5:0], r.rd[4:1], 1'b0};
         IMM_U:   immE = {r.funct7, r.rs2, r.rs1, r.funct3, 12'b0};
         IMM_J:   immE = {{12{r.funct7[6]}}, r.rs1, r.funct3, r.rs2[0],
                          r.funct7[5:0], r.rs2[4:1], 1'b0};
         default: immE = {{20{i.imm[11]}}, i.imm};
      endcase
   end

   // no register writes while the core is held in reset
   assign rfWe = regWriteE & rstN;

   cpu6_regfile regfile (
      .clk (clk),
      .rs1 (r.rs1),
      .rs2 (r.rs2),
      .rd  (r.rd),
      .we  (rfWe),
      .wd  (resultE),
      .rd1 (rd1),
      .rd2 (rd2)
   );

   assign srcB = aluSrcE ? immE : rd2;

   cpu6_alu alu (
      .a    (rd1),
      .b    (srcB),
      .op   (aluOpE),
      .y    (aluY),
      .zero (aluZero)
   );

   // BEQ and BNE compare through the ALU subtraction
   assign branchTaken = ((branchTypeE == BR_EQ) &  aluZero) |
                        ((branchTypeE == BR_NE) & ~aluZero);
   assign pcSrcE      = jumpE | branchTaken;
   assign pcNextE     = pcE + immE;

   assign memWrite  = memWriteE;
   assign dataAddr  = aluY;
   assign writeData = rd2;

   assign csrAddrE  = i.imm;
   assign csrWdataE = rd1;

   always_comb begin
      if (jumpE) resultE = pcE + `CPU6_XLEN'd4;
      else if (memToRegE) resultE = readData;
      else if (csrOpE != CSR_NONE) resultE = csrRdata;
      else resultE = aluY;
   end

endmodule

/* datapath/cpu6_regfile.sv */
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module cpu6_regfile (
   input  logic                  clk,
   input  logic [4:0]            rs1,
   input  logic [4:0]            rs2,
   input  logic [4:0]            rd,
   input  logic                  we,
   input  logic [`CPU6_XLEN-1:0] wd,
   output logic [`CPU6_XLEN-1:0] rd1,
   output logic [`CPU6_XLEN-1:0] rd2
);

   logic [`CPU6_XLEN-1:0] regs [32];

   // x0 is never written and always reads zero
   always_ff @(posedge clk) begin
      if (we && rd != 5'd0) begin
         regs[rd] <= wd;
      end
   end

   assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
   assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* datapath/cpu6_alu.sv */
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module cpu6_alu (
   input  logic [`CPU6_XLEN-1:0] a,
   input  logic [`CPU6_XLEN-1:0] b,
   input  cpu6_ctrl_pkg::aluOp_e op,
   output logic [`CPU6_XLEN-1:0] y,
   output logic                  zero
);
   import cpu6_ctrl_pkg::*;

   always_comb begin
      case (op)
         ALU_ADD:   y = a + b;
         ALU_SUB:   y = a - b;
         ALU_AND:   y = a & b;
         ALU_OR:    y = a | b;
         // LUI passes the immediate straight through
         ALU_PASSB: y = b;
         default:   y = '0;
      endcase
   end

   assign zero = (y == '0);

endmodule

/* common/cpu6_ctrl_pkg.sv */
package cpu6_ctrl_pkg;

   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,
      ALU_SUB   = 3'd1,
      ALU_AND   = 3'd2,
      ALU_OR    = 3'd3,
      ALU_PASSB = 3'd4
   } aluOp_e;

   // immediate format to rebuild in E
   typedef enum logic [2:0] {
      IMM_I = 3'd0,
      IMM_S = 3'd1,
      IMM_B = 3'd2,
      IMM_U = 3'd3,
      IMM_J = 3'd4
   } immType_e;

   typedef enum logic [1:0] {
      BR_NONE = 2'd0,
      BR_EQ   = 2'd1,
      BR_NE   = 2'd2
   } branchType_e;

   typedef enum logic [1:0] {
      CSR_NONE  = 2'd0,
      CSR_WRITE = 2'd1,
      CSR_SET   = 2'd2
   } csrOp_e;

endpackage

/* common/cpu6_isa_pkg.sv */
`include "cpu6_defines.svh"

package cpu6_isa_pkg;

   // base opcodes of the implemented subset
   typedef enum logic [`CPU6_OPCODE_HIGH:`CPU6_OPCODE_LOW] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111,
      OPC_SYSTEM = 7'b1110011
   } opcode_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
   } rType_s;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_e     opcode;
   } iType_s;

   // one instruction word seen as R-type or as I-type
   typedef union packed {
      rType_s rType;
      iType_s iType;
   } instrWord_u;

   localparam logic [11:0] CSR_MTVEC = 12'h305;
   localparam logic [11:0] CSR_MEPC  = 12'h341;

endpackage

/* common/cpu6_defines.svh */
`ifndef CPU6_DEFINES_SVH
`define CPU6_DEFINES_SVH

// data and address word width
`define CPU6_XLEN 32

// first fetch address after reset
`define CPU6_RESET_PC 32'h0000_0000

// opcode field bounds in every instruction format
`define CPU6_OPCODE_HIGH 6
`define CPU6_OPCODE_LOW 0

`endif
